// ==== common/cyc_bram_consts.svh ====
// Sizes, read latency and register offsets of the cyclic weight store; include where needed
`ifndef CYC_BRAM_CONSTS_SVH
`define CYC_BRAM_CONSTS_SVH

// RAM geometry
`define CB_W_DEPTH 16
`define CB_W_WIDTH 16
`define CB_R_WIDTH 8
`define CB_LANES 2
`define CB_R_DEPTH 32
`define CB_W_AW 4
`define CB_R_AW 5

`define CB_LATENCY 3  // RAM read latency in cycles

// Wishbone word offsets
`define CB_REG_W_MAX 2'd0
`define CB_REG_R_MIN 2'd1
`define CB_REG_R_MAX 2'd2
`define CB_REG_CTRL 2'd3

`endif

// ==== common/cyc_bram_pkg.sv ====
// Types shared by the cyclic store, its RAM and the register port; compile before the RTL
`include "cyc_bram_consts.svh"

package cyc_bram_pkg;

  // ==============================
  // Sequencer states
  // ==============================
  typedef enum logic [1:0] {
    WRITE  = 2'd0,  // taking input beats
    FILL_1 = 2'd1,  // priming reads
    FILL_2 = 2'd2,  // waiting for buffer to fill
    READ   = 2'd3   // endless output stream
  } cyc_state_e;

  // ==============================
  // RAM word
  // ==============================
  // Written whole, read back one lane at a time
  // Lane 0 sits in the low bits
  typedef union packed {
    logic [`CB_W_WIDTH-1:0] word;
    logic [`CB_LANES-1:0][`CB_R_WIDTH-1:0] lane;
  } cyc_word_u;

endpackage

// ==== logic/sdp_ram.sv ====
// Behavioural dual-port RAM with wide writes, lane reads and a pipelined read path
`include "cyc_bram_consts.svh"

module sdp_ram #(
  parameter int LATENCY = `CB_LATENCY
) (
  input  logic                   clk,
  input  logic                   clken,
  input  logic                   we,
  input  logic [`CB_W_AW-1:0]    w_addr,
  input  logic [`CB_W_WIDTH-1:0] w_data,
  input  logic                   re,
  input  logic [`CB_R_AW-1:0]    r_addr,
  output logic [`CB_R_WIDTH-1:0] r_data,
  output logic                   r_valid
);
  import cyc_bram_pkg::*;

  cyc_word_u mem [`CB_W_DEPTH];

  // Stage 0 of the read pipe is the array output register
  logic [`CB_R_WIDTH-1:0] data_pipe [LATENCY];
  logic [LATENCY-1:0]     valid_pipe;

  // Upper address bits pick the word, bit 0 picks the lane
  logic [`CB_W_AW-1:0] r_word;
  logic                r_lane;

  assign r_word = r_addr[`CB_R_AW-1:1];
  assign r_lane = r_addr[0];

  always_ff @(posedge clk) begin
    if (clken) begin
      if (we) begin
        mem[w_addr].word <= w_data;
      end
      data_pipe[0]  <= mem[r_word].lane[r_lane];
      valid_pipe[0] <= re;
      for (int i = 1; i < LATENCY; i++) begin
        data_pipe[i]  <= data_pipe[i-1];
        valid_pipe[i] <= valid_pipe[i-1];
      end
    end
  end

  assign r_data  = data_pipe[LATENCY-1];
  assign r_valid = valid_pipe[LATENCY-1];  // lines up with r_data

endmodule

// ==== cyclic_bram/always_valid_cyclic_bram.sv ====
// Cyclic weight store; written once, then read in an endless loop with RAM latency hidden
`include "cyc_bram_consts.svh"

module always_valid_cyclic_bram #(
  parameter int LATENCY = `CB_LATENCY
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clken,
  input  logic                        restart,
  input  logic                        s_valid_ready,
  input  logic [`CB_W_WIDTH-1:0]      s_data,
  output logic                        m_valid,
  input  logic                        m_ready,
  output logic [`CB_R_WIDTH-1:0]      m_data,
  input  logic [`CB_R_AW-1:0]         r_addr_max,
  input  logic [`CB_R_AW-1:0]         r_addr_min,
  input  logic [`CB_W_AW-1:0]         w_addr_max,
  output cyc_bram_pkg::cyc_state_e    state
);
  import cyc_bram_pkg::*;

  localparam int BUF_DEPTH = LATENCY + 1;
  localparam int PTR_W     = $clog2(BUF_DEPTH);
  localparam int CNT_W     = $clog2(LATENCY + 1);

  localparam logic [PTR_W-1:0] PTR_LAST  = PTR_W'(BUF_DEPTH - 1);
  localparam logic [CNT_W-1:0] FLUSH_LEN = CNT_W'(LATENCY);

  cyc_state_e state_next;

  logic                   clear;     // rst or restart
  logic                   xfer;      // output beat taken
  logic                   ram_we;
  logic                   ram_re;
  logic [`CB_R_WIDTH-1:0] ram_data;
  logic                   ram_valid;
  logic                   buf_push;

  logic [`CB_W_AW-1:0] w_addr;
  logic [`CB_R_AW-1:0] r_addr;
  logic [`CB_R_AW-1:0] r_addr_next;

  logic [CNT_W-1:0] flush_cnt;
  logic [PTR_W-1:0] w_ptr;
  logic [PTR_W-1:0] r_ptr;

  logic [`CB_R_WIDTH-1:0] buffer [BUF_DEPTH];

  assign clear  = rst || restart;
  assign xfer   = m_valid && m_ready;
  assign ram_we = (state == WRITE) && s_valid_ready;  // later writes dropped

  // ==============================
  // Sequencer
  // ==============================
  always_comb begin
    state_next = state;
    case (state)
      WRITE:  if (ram_we && (w_addr == w_addr_max)) state_next = FILL_1;
      FILL_1: if (buf_push) state_next = FILL_2;  // first read is back
      FILL_2: if (buf_push && (w_ptr == PTR_LAST)) state_next = READ;
      default: state_next = state;
    endcase
  end

  // FILL_1 primes BUF_DEPTH reads, after that one read per beat taken
  always_comb begin
    case (state)
      WRITE:   ram_re = 1'b0;
      FILL_1:  ram_re = 1'b1;
      default: ram_re = m_ready;
    endcase
  end

  // Slot 0 is loaded by the time FILL_2 starts
  assign m_valid = (state == FILL_2) || (state == READ);

  always_ff @(posedge clk) begin
    if (clear) begin
      state <= WRITE;
    end else if (clken) begin
      state <= state_next;
    end
  end

  // ==============================
  // Address counters
  // ==============================
  always_ff @(posedge clk) begin
    if (clear) begin
      w_addr <= '0;
    end else if (clken && ram_we) begin
      w_addr <= w_addr + 1'b1;
    end
  end

  // Wraps to r_addr_min so the config prefix is read only once
  assign r_addr_next = (r_addr == r_addr_max) ? r_addr_min : r_addr + 1'b1;

  always_ff @(posedge clk) begin
    if (clear) begin
      r_addr <= '0;
    end else if (clken && ram_re) begin
      r_addr <= r_addr_next;
    end
  end

  sdp_ram #(
    .LATENCY (LATENCY)
  ) ram0 (
    .clk     (clk),
    .clken   (clken),
    .we      (ram_we),
    .w_addr  (w_addr),
    .w_data  (s_data),
    .re      (ram_re),
    .r_addr  (r_addr),
    .r_data  (ram_data),
    .r_valid (ram_valid)
  );

  // ==============================
  // Latency-hiding buffer
  // ==============================
  // Reads still in flight at a clear come out during the first LATENCY cycles
  always_ff @(posedge clk) begin
    if (clear) begin
      flush_cnt <= FLUSH_LEN;
    end else if (clken && (flush_cnt != '0)) begin
      flush_cnt <= flush_cnt - 1'b1;
    end
  end

  assign buf_push = ram_valid && (flush_cnt == '0);

  always_ff @(posedge clk) begin
    if (clear) begin
      w_ptr <= '0;
    end else if (clken && buf_push) begin
      w_ptr <= (w_ptr == PTR_LAST) ? '0 : w_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (clken && buf_push) begin
      buffer[w_ptr] <= ram_data;
    end
  end

  always_ff @(posedge clk) begin
    if (clear) begin
      r_ptr <= '0;
    end else if (clken && xfer) begin
      r_ptr <= (r_ptr == PTR_LAST) ? '0 : r_ptr + 1'b1;
    end
  end

  assign m_data = buffer[r_ptr];  // steady until r_ptr moves

endmodule

// ==== logic/wb_cfg_regs.sv ====
// Wishbone classic register port for the store limits, restart command and status
`include "cyc_bram_consts.svh"

module wb_cfg_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [1:0]               wb_adr,
  input  logic [31:0]              wb_dat_w,
  output logic                     wb_ack,
  output logic [31:0]              wb_dat_r,
  output logic [`CB_W_AW-1:0]      w_addr_max,
  output logic [`CB_R_AW-1:0]      r_addr_min,
  output logic [`CB_R_AW-1:0]      r_addr_max,
  output logic                     restart,
  input  cyc_bram_pkg::cyc_state_e state
);

  logic        req;  // first cycle of an access
  logic        wr;
  logic [31:0] rd_mux;

  // No request in the ack cycle, so every access takes two cycles
  assign req = wb_cyc && wb_stb && !wb_ack;
  assign wr  = req && wb_we;

  // ==============================
  // Handshake and restart
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack  <= 1'b0;
      restart <= 1'b0;
    end else begin
      wb_ack  <= req;
      // Pulses together with the ack
      restart <= wr && (wb_adr == `CB_REG_CTRL) && wb_dat_w[0];
    end
  end

  // ==============================
  // Limit registers
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      w_addr_max <= `CB_W_AW'(`CB_W_DEPTH - 1);
      r_addr_min <= '0;
      r_addr_max <= `CB_R_AW'(`CB_R_DEPTH - 1);
    end else if (wr) begin
      case (wb_adr)
        `CB_REG_W_MAX: w_addr_max <= wb_dat_w[`CB_W_AW-1:0];
        `CB_REG_R_MIN: r_addr_min <= wb_dat_w[`CB_R_AW-1:0];
        `CB_REG_R_MAX: r_addr_max <= wb_dat_w[`CB_R_AW-1:0];
        default: ;  // CTRL holds no state
      endcase
    end
  end

  // Readback
  always_comb begin
    case (wb_adr)
      `CB_REG_W_MAX: rd_mux = {{(32 - `CB_W_AW){1'b0}}, w_addr_max};
      `CB_REG_R_MIN: rd_mux = {{(32 - `CB_R_AW){1'b0}}, r_addr_min};
      `CB_REG_R_MAX: rd_mux = {{(32 - `CB_R_AW){1'b0}}, r_addr_max};
      default:       rd_mux = {30'd0, state};  // live state in bits 1:0
    endcase
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_mux;  // valid with wb_ack
    end
  end

endmodule

// ==== logic/cyclic_bram_top.sv ====
// Top level of the cyclic weight store with its Wishbone configuration port
`include "cyc_bram_consts.svh"

module cyclic_bram_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clken,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [1:0]             wb_adr,
  input  logic [31:0]            wb_dat_w,
  output logic                   wb_ack,
  output logic [31:0]            wb_dat_r,
  input  logic                   s_valid_ready,
  input  logic [`CB_W_WIDTH-1:0] s_data,
  output logic                   m_valid,
  input  logic                   m_ready,
  output logic [`CB_R_WIDTH-1:0] m_data
);
  import cyc_bram_pkg::*;

  // Between register port and store
  logic [`CB_W_AW-1:0] w_addr_max;
  logic [`CB_R_AW-1:0] r_addr_min;
  logic [`CB_R_AW-1:0] r_addr_max;
  logic                restart;
  cyc_state_e          state;

  // Register port runs without clken
  wb_cfg_regs regs0 (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r),
    .w_addr_max (w_addr_max),
    .r_addr_min (r_addr_min),
    .r_addr_max (r_addr_max),
    .restart    (restart),
    .state      (state)
  );

  always_valid_cyclic_bram #(
    .LATENCY (`CB_LATENCY)
  ) store0 (
    .clk           (clk),
    .rst           (rst),
    .clken         (clken),
    .restart       (restart),
    .s_valid_ready (s_valid_ready),
    .s_data        (s_data),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .m_data        (m_data),
    .r_addr_max    (r_addr_max),
    .r_addr_min    (r_addr_min),
    .w_addr_max    (w_addr_max),
    .state         (state)
  );

endmodule

// ==== bench/cyclic_bram_assertions.sv ====
// Protocol checks bound into every cyclic store instance; compiled with the testbench
`include "cyc_bram_consts.svh"

module cyclic_bram_assertions (
  input logic                     clk,
  input logic                     rst,
  input logic                     restart,
  input logic                     m_valid,
  input logic                     m_ready,
  input logic [`CB_R_WIDTH-1:0]   m_data,
  input cyc_bram_pkg::cyc_state_e state
);
  import cyc_bram_pkg::*;

  int fail_count = 0;  // read by the testbench

  // Always-valid once filled
  assert property (@(posedge clk) (m_valid && !rst && !restart) |=> m_valid)
    else begin
      $error("m_valid fell without reset or restart");
      fail_count++;
    end

  // Output holds under back-pressure
  assert property (@(posedge clk)
      (m_valid && !m_ready && !rst && !restart) |=> $stable(m_data))
    else begin
      $error("m_data changed while stalled");
      fail_count++;
    end

  // State walks from WRITE to READ one step at a time
  assert property (@(posedge clk) (!rst && !restart) |=>
      (state == $past(state)) ||
      (($past(state) != READ) && (2'(state) == 2'($past(state)) + 2'd1)))
    else begin
      $error("state moved backward or skipped a step");
      fail_count++;
    end

endmodule

bind always_valid_cyclic_bram cyclic_bram_assertions asrt0 (
  .clk     (clk),
  .rst     (rst),
  .restart (restart),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_data  (m_data),
  .state   (state)
);

// ==== bench/cyclic_bram_tb.sv ====
// Self-checking testbench for the cyclic weight store; run from the project root via the Makefile
`include "cyc_bram_consts.svh"

module cyclic_bram_tb;
  import cyc_bram_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RUNS       = 2;                   // first fill, then refill after restart
  localparam int XFERS      = 4 * `CB_R_DEPTH;     // per run, enough for three passes
  localparam int ACK_LIMIT  = 8;
  localparam int RISE_BOUND = `CB_LATENCY + 4;
  localparam int WATCHDOG_CYCLES = 200 * XFERS * RUNS;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   clken;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [1:0]             wb_adr;
  logic [31:0]            wb_dat_w;
  logic                   wb_ack;
  logic [31:0]            wb_dat_r;
  logic                   s_valid_ready;
  logic [`CB_W_WIDTH-1:0] s_data;
  logic                   m_valid;
  logic                   m_ready;
  logic [`CB_R_WIDTH-1:0] m_data;

  // Reference model
  logic [`CB_W_WIDTH-1:0] model_mem [`CB_W_DEPTH];
  int unsigned            w_max;
  int unsigned            r_min;
  int unsigned            r_max;

  cyclic_bram_top dut0 (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==============================
  // Reporting
  // ==============================
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    stop_with_failure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_idle();
    assert (!m_valid) else value_error("m_valid", 32'(m_valid), 32'd0);
  endtask

  // Read lane of the model word; lane 0 is the low byte
  function automatic logic [`CB_R_WIDTH-1:0] model_lane(input int unsigned addr);
    logic [`CB_W_WIDTH-1:0] word;
    word = model_mem[addr / `CB_LANES];
    return word[(addr % `CB_LANES) * `CB_R_WIDTH +: `CB_R_WIDTH];
  endfunction

  // ==============================
  // Wishbone master
  // ==============================
  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat_w,
                           output logic [31:0] dat_r);
    int waited;
    waited = 0;
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat_w;
    do begin
      @(posedge clk);
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    assert (wb_ack) else stop_with_failure("Wishbone access was never acknowledged");
    dat_r  = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(posedge clk);
    assert (!wb_ack) else stop_with_failure("Wishbone acknowledge repeated for a single access");
  endtask

  task automatic write_reg(input logic [1:0] adr, input logic [31:0] dat);
    logic [31:0] discard;
    wb_access(1'b1, adr, dat, discard);
  endtask

  task automatic check_reg(input logic [1:0] adr, input logic [31:0] exp);
    logic [31:0] got;
    wb_access(1'b0, adr, 32'd0, got);
    assert (got == exp) else value_error("wb_dat_r", got, exp);
  endtask

  // Read range stays inside the words that get written
  task automatic set_random_limits();
    w_max = 4 + $urandom % 12;
    r_max = 1 + $urandom % (2 * w_max + 1);
    r_min = $urandom % (r_max + 1);
    write_reg(`CB_REG_W_MAX, 32'(w_max));
    write_reg(`CB_REG_R_MIN, 32'(r_min));
    write_reg(`CB_REG_R_MAX, 32'(r_max));
    check_reg(`CB_REG_W_MAX, 32'(w_max));
    check_reg(`CB_REG_R_MIN, 32'(r_min));
    check_reg(`CB_REG_R_MAX, 32'(r_max));
  endtask

  // ==============================
  // Stream phases
  // ==============================
  task automatic fill_store();
    int unsigned            gap;
    int                     cycles;
    logic [`CB_W_WIDTH-1:0] word;
    for (int i = 0; i <= int'(w_max); i++) begin
      gap = $urandom % 3;
      s_valid_ready <= 1'b0;
      repeat (gap) begin
        @(posedge clk);
        check_idle();
      end
      word = `CB_W_WIDTH'($urandom);
      model_mem[i] = word;
      s_valid_ready <= 1'b1;
      s_data        <= word;
      @(posedge clk);
      check_idle();
    end
    s_valid_ready <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!m_valid && cycles <= RISE_BOUND);
    assert (m_valid && cycles <= RISE_BOUND)
      else stop_with_failure("m_valid did not rise within the latency bound after the fill");
  endtask

  task automatic stream_and_check();
    int unsigned            addr;
    int                     xfers;
    logic [`CB_R_WIDTH-1:0] exp;
    addr  = 0;
    xfers = 0;
    while (xfers < XFERS) begin
      m_ready       <= ($urandom % 4) != 0;
      clken         <= ($urandom % 8) != 0;
      s_valid_ready <= 1'($urandom);       // read phase writes must be dropped
      s_data        <= `CB_W_WIDTH'($urandom);
      @(posedge clk);
      if (m_valid && m_ready && clken) begin
        exp = model_lane(addr);
        assert (m_data == exp) else value_error("m_data", 32'(m_data), 32'(exp));
        if (addr == r_max) begin
          addr = r_min;
        end else begin
          addr++;
        end
        xfers++;
      end
    end
    m_ready       <= 1'b0;
    clken         <= 1'b1;
    s_valid_ready <= 1'b0;
  endtask

  task automatic restart_store();
    write_reg(`CB_REG_CTRL, 32'd1);
    check_idle();
    check_reg(`CB_REG_CTRL, 32'(WRITE));
  endtask

  // Flags any failure of the bound assertions
  always @(posedge clk) begin
    assert (dut0.store0.asrt0.fail_count == 0)
      else stop_with_failure("a bound protocol assertion on the store failed");
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_with_failure("Timeout: the run did not finish within the watchdog limit");
  end

  initial begin
    void'($urandom(55));
    rst           <= 1'b1;
    clken         <= 1'b1;
    wb_cyc        <= 1'b0;
    wb_stb        <= 1'b0;
    wb_we         <= 1'b0;
    wb_adr        <= 2'd0;
    wb_dat_w      <= 32'd0;
    s_valid_ready <= 1'b0;
    s_data        <= '0;
    m_ready       <= 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Reset values
    check_idle();
    check_reg(`CB_REG_W_MAX, 32'(`CB_W_DEPTH - 1));
    check_reg(`CB_REG_R_MIN, 32'd0);
    check_reg(`CB_REG_R_MAX, 32'(`CB_R_DEPTH - 1));
    check_reg(`CB_REG_CTRL, 32'(WRITE));

    for (int run = 0; run < RUNS; run++) begin
      if (run > 0) begin
        restart_store();
      end
      set_random_limits();
      fill_store();
      stream_and_check();
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+common
common/cyc_bram_pkg.sv
logic/sdp_ram.sv
cyclic_bram/always_valid_cyclic_bram.sv
logic/wb_cfg_regs.sv
logic/cyclic_bram_top.sv
bench/cyclic_bram_assertions.sv
bench/cyclic_bram_tb.sv

// ==== Makefile ====
# Verilator build and run of the cyclic weight store testbench

VERILATOR ?= verilator
TOP       ?= cyclic_bram_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
